/* filelist.f */
kd_pkg.sv
kd_internal_node.sv
kd_node_loader.sv
kd_tree_pipe.sv
kd_leaf_encoder.sv
kd_search_top.sv
kd_search_sva.sv
tb_kd_search.sv

/* kd_internal_node.sv */
`timescale 1ns/100ps

module kd_internal_node (
    input  logic               clk,
    input  logic               rst_n,
    // config write, not pipelined
    input  logic               wen_i,
    input  kd_pkg::node_cfg_t  wdata_i,
    // valid and patch for this node's level
    input  logic               valid_i,
    input  kd_pkg::patch_t     patch_i,
    // steered valid towards the children
    output logic               left_o,
    output logic               right_o,
    // stored word, for readback
    output kd_pkg::node_cfg_t  cfg_o
);

    kd_pkg::node_cfg_t cfg_q;
    kd_pkg::elem_t     sel_elem;
    logic              go_right;

    // config register, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (wen_i) begin
            cfg_q <= wdata_i;
        end
    end

    // pick the element named by dim
    assign sel_elem = patch_i[cfg_q.dim];

    // strictly greater goes right, equal stays left
    assign go_right = (sel_elem > cfg_q.median);

    // exactly one child sees the valid
    assign left_o  = valid_i & ~go_right;
    assign right_o = valid_i &  go_right;

    assign cfg_o = cfg_q;

endmodule

/* kd_leaf_encoder.sv */
`timescale 1ns/100ps

module kd_leaf_encoder #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // one-hot valids from the last tree level
    input  logic [(2**DEPTH)-1:0]     leaf_onehot_i,
    // registered result
    output logic                      leaf_valid_o,
    output kd_pkg::leaf_t             leaf_index_o
);

    localparam int LEAVES = 2**DEPTH;

    kd_pkg::leaf_t enc_index;
    logic          any_leaf;
    logic          leaf_valid_q;
    kd_pkg::leaf_t leaf_index_q;

    // priority encode, highest set bit wins
    // only one bit is ever set in normal use
    always_comb begin
        enc_index = '0;
        for (int k = 0; k < LEAVES; k++) begin
            if (leaf_onehot_i[k]) begin
                enc_index = kd_pkg::leaf_t'(k);
            end
        end
    end

    assign any_leaf = |leaf_onehot_i;

    // strobe, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            leaf_valid_q <= 1'b0;
        end else begin
            leaf_valid_q <= any_leaf;
        end
    end

    // index holds between results
    always_ff @(posedge clk) begin
        if (any_leaf) begin
            leaf_index_q <= enc_index;
        end
    end

    assign leaf_valid_o = leaf_valid_q;
    assign leaf_index_o = leaf_index_q;

endmodule

/* kd_node_loader.sv */
`timescale 1ns/100ps

module kd_node_loader #(
    parameter int DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // streaming load, auto-incrementing address
    input  logic                                  cfg_load_i,
    input  kd_pkg::node_cfg_t                     cfg_data_i,
    // addressed host port
    input  logic                                  host_we_i,
    input  logic                                  host_re_i,
    input  kd_pkg::node_addr_t                    host_addr_i,
    input  kd_pkg::node_cfg_t                     host_data_i,
    // every node's stored word, used for readback
    input  kd_pkg::node_cfg_t [(2**DEPTH)-2:0]    node_cfg_all_i,
    // write side towards the tree
    output logic [(2**DEPTH)-2:0]                 node_wen_o,
    output kd_pkg::node_cfg_t                     node_wdata_o,
    // registered readback
    output logic                                  host_rd_valid_o,
    output kd_pkg::node_cfg_t                     host_rd_data_o
);

    // number of internal nodes in the tree
    localparam int NODES = (2**DEPTH) - 1;

    // last stream address before the wrap
    localparam kd_pkg::node_addr_t LAST_ADDR = kd_pkg::node_addr_t'(NODES - 1);

    kd_pkg::node_addr_t node_addr_q;
    kd_pkg::node_addr_t wr_addr;
    logic               wr_en;
    logic               stream_wr;
    logic               rd_in_range;
    logic               rd_valid_q;
    kd_pkg::node_cfg_t  rd_data_q;

    // host write wins, stream word is dropped then
    assign stream_wr = cfg_load_i & ~host_we_i;
    assign wr_en     = host_we_i | cfg_load_i;

    // address and data from the winning source
    assign wr_addr      = host_we_i ? host_addr_i : node_addr_q;
    assign node_wdata_o = host_we_i ? host_data_i : cfg_data_i;

    // one-hot decode of the write address
    // addresses past the last node hit nothing
    always_comb begin
        node_wen_o = '0;
        for (int a = 0; a < NODES; a++) begin
            if (wr_en && (wr_addr == kd_pkg::node_addr_t'(a))) begin
                node_wen_o[a] = 1'b1;
            end
        end
    end

    // stream address counter
    // moves only on an accepted stream word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            node_addr_q <= '0;
        end else if (stream_wr) begin
            if (node_addr_q == LAST_ADDR) begin
                node_addr_q <= '0;
            end else begin
                node_addr_q <= node_addr_q + 1'b1;
            end
        end
    end

    // readback range check
    assign rd_in_range = (host_addr_i < kd_pkg::node_addr_t'(NODES));

    // read strobe, one cycle behind host_re_i
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= host_re_i;
        end
    end

    // read word, out of range reads give zero
    always_ff @(posedge clk) begin
        if (host_re_i) begin
            rd_data_q <= rd_in_range ? node_cfg_all_i[host_addr_i] : '0;
        end
    end

    assign host_rd_valid_o = rd_valid_q;
    assign host_rd_data_o  = rd_data_q;

endmodule

/* kd_pkg.sv */
// shared types and sizes for the kd-tree search engine
package kd_pkg;

    // width of one patch element
    localparam int ELEM_W = 8;

    // elements per patch
    localparam int DIMS = 4;

    // enough bits to pick one of DIMS elements
    localparam int DIM_W = 2;

    // deepest tree the address and leaf types can hold
    localparam int MAX_DEPTH = 6;

    // one unsigned patch element
    typedef logic [ELEM_W-1:0] elem_t;

    // dimension select stored in each node
    typedef logic [DIM_W-1:0] dim_t;

    // full patch, element 0 sits in the low bits
    typedef elem_t [DIMS-1:0] patch_t;

    // stored content of one internal node
    typedef struct packed {
        // which patch element to compare
        dim_t  dim;
        // split value, greater goes right
        elem_t median;
    } node_cfg_t;

    // heap address, root at 0
    // node at level i, position j lives at 2^i - 1 + j
    typedef logic [MAX_DEPTH-1:0] node_addr_t;

    // leaf position at the last level
    // first decision ends up as the msb
    typedef logic [MAX_DEPTH-1:0] leaf_t;

endpackage

/* kd_search_sva.sv */
`timescale 1ns/100ps

module kd_search_sva #(
    parameter int DEPTH = 4
) (
    input logic          clk,
    input logic          rst_n,
    input logic          patch_valid_i,
    input logic          leaf_valid_i,
    input kd_pkg::leaf_t leaf_index_i,
    input logic          host_re_i,
    input logic          host_rd_valid_i
);

    // a patch taken while out of reset comes out DEPTH+2 cycles later
    // reset lasts longer than the pipe, so a killed patch never reaches here
    a_leaf_latency: assert property (@(posedge clk) disable iff (!rst_n)
        leaf_valid_i == $past(patch_valid_i && rst_n, DEPTH + 2))
        else $error("leaf_valid_o does not follow patch_valid_i by %0d cycles", DEPTH + 2);

    // read strobe exactly one cycle after the request
    a_read_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid_i == $past(host_re_i && rst_n))
        else $error("host_rd_valid_o does not follow host_re_i by one cycle");

    // index must be known whenever it is flagged valid
    a_leaf_known: assert property (@(posedge clk) disable iff (!rst_n)
        leaf_valid_i |-> !$isunknown(leaf_index_i))
        else $error("leaf_index_o unknown while leaf_valid_o is high");

endmodule

bind kd_search_top kd_search_sva #(
    .DEPTH (DEPTH)
) u_kd_search_sva (
    .clk             (clk),
    .rst_n           (rst_n),
    .patch_valid_i   (patch_valid_i),
    .leaf_valid_i    (leaf_valid_o),
    .leaf_index_i    (leaf_index_o),
    .host_re_i       (host_re_i),
    .host_rd_valid_i (host_rd_valid_o)
);

/* kd_search_top.sv */
`timescale 1ns/100ps

module kd_search_top #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    // streaming node load
    input  logic                cfg_load_i,
    input  kd_pkg::node_cfg_t   cfg_data_i,
    // addressed host port
    input  logic                host_we_i,
    input  logic                host_re_i,
    input  kd_pkg::node_addr_t  host_addr_i,
    input  kd_pkg::node_cfg_t   host_data_i,
    output logic                host_rd_valid_o,
    output kd_pkg::node_cfg_t   host_rd_data_o,
    // search in and out
    input  logic                patch_valid_i,
    input  kd_pkg::patch_t      patch_i,
    output logic                leaf_valid_o,
    output kd_pkg::leaf_t       leaf_index_o
);

    // loader to tree
    logic [(2**DEPTH)-2:0]               node_wen;
    kd_pkg::node_cfg_t                   node_wdata;

    // tree back to loader, for readback
    kd_pkg::node_cfg_t [(2**DEPTH)-2:0]  node_cfg_all;

    // tree to encoder
    logic [(2**DEPTH)-1:0]               leaf_onehot;

    // input side, 1 cycle write and read
    kd_node_loader #(
        .DEPTH (DEPTH)
    ) u_kd_node_loader (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_load_i      (cfg_load_i),
        .cfg_data_i      (cfg_data_i),
        .host_we_i       (host_we_i),
        .host_re_i       (host_re_i),
        .host_addr_i     (host_addr_i),
        .host_data_i     (host_data_i),
        .node_cfg_all_i  (node_cfg_all),
        .node_wen_o      (node_wen),
        .node_wdata_o    (node_wdata),
        .host_rd_valid_o (host_rd_valid_o),
        .host_rd_data_o  (host_rd_data_o)
    );

    // DEPTH+1 register levels
    kd_tree_pipe #(
        .DEPTH (DEPTH)
    ) u_kd_tree_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .patch_valid_i  (patch_valid_i),
        .patch_i        (patch_i),
        .node_wen_i     (node_wen),
        .node_wdata_i   (node_wdata),
        .node_cfg_all_o (node_cfg_all),
        .leaf_onehot_o  (leaf_onehot)
    );

    // one more register for the result
    kd_leaf_encoder #(
        .DEPTH (DEPTH)
    ) u_kd_leaf_encoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .leaf_onehot_i (leaf_onehot),
        .leaf_valid_o  (leaf_valid_o),
        .leaf_index_o  (leaf_index_o)
    );

endmodule

/* kd_tree_pipe.sv */
`timescale 1ns/100ps

module kd_tree_pipe #(
    parameter int DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // new patch, one per cycle at most
    input  logic                                  patch_valid_i,
    input  kd_pkg::patch_t                        patch_i,
    // node writes from the loader
    input  logic [(2**DEPTH)-2:0]                 node_wen_i,
    input  kd_pkg::node_cfg_t                     node_wdata_i,
    // all stored node words
    output kd_pkg::node_cfg_t [(2**DEPTH)-2:0]    node_cfg_all_o,
    // one-hot valids at the leaf level
    output logic [(2**DEPTH)-1:0]                 leaf_onehot_o
);

    // internal nodes
    localparam int NODES = (2**DEPTH) - 1;

    // leaves at the last level
    localparam int LEAVES = 2**DEPTH;

    // every heap slot, nodes plus leaves
    localparam int SLOTS = NODES + LEAVES;

    // patch copy per level, levels 0 to DEPTH-1
    // the leaf level needs no patch
    kd_pkg::patch_t patch_q [DEPTH];

    // registered valid per heap slot
    // slot a has children 2a+1 and 2a+2
    logic [SLOTS-1:0] valid_q;

    // steered valids out of the nodes, slot 0 has no parent
    logic [SLOTS-1:1] child_v;

    // level 0 takes the input patch every cycle
    // later levels shift down one per edge
    always_ff @(posedge clk) begin
        patch_q[0] <= patch_i;
        for (int l = 1; l < DEPTH; l++) begin
            patch_q[l] <= patch_q[l-1];
        end
    end

    // valid pipeline
    // root only set for a real patch, the rest follow the children
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0]         <= patch_valid_i;
            valid_q[SLOTS-1:1] <= child_v;
        end
    end

    // tree of nodes, level by level
    for (genvar i = 0; i < DEPTH; i++) begin : g_level
        for (genvar j = 0; j < (2**i); j++) begin : g_node
            // heap address of this node
            localparam int A = (2**i) - 1 + j;

            kd_internal_node u_node (
                .clk     (clk),
                .rst_n   (rst_n),
                .wen_i   (node_wen_i[A]),
                .wdata_i (node_wdata_i),
                .valid_i (valid_q[A]),
                .patch_i (patch_q[i]),
                .left_o  (child_v[2*A+1]),
                .right_o (child_v[2*A+2]),
                .cfg_o   (node_cfg_all_o[A])
            );
        end
    end

    // leaves occupy the top LEAVES slots
    // leaf 0 is the leftmost one
    assign leaf_onehot_o = valid_q[SLOTS-1:NODES];

endmodule

/* run.sh */
#!/bin/sh
# build and run the kd-tree search testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
    --top-module tb_kd_search \
    -f filelist.f \
    -o sim_kd_search

# keep going after a failing run so the log check decides
./obj_dir/sim_kd_search > sim.log 2>&1 || true
cat sim.log

if grep -q "No errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* tb_kd_search.sv */
`timescale 1ns/100ps

module tb_kd_search;

    localparam int DEPTH = 4;
    localparam int NODES = (2**DEPTH) - 1;
    // patch in to leaf out in clock cycles
    localparam int LAT = DEPTH + 2;
    localparam int N_ROWS = 8;
    localparam int N_RAND = 64;
    localparam int TBL_LEN = NODES + N_ROWS;
    // table and random set run more than once plus drains and readback
    localparam int WATCHDOG_CYCLES = 4 * (TBL_LEN + N_RAND) + 50;

    // one patch row of the table
    typedef struct packed {
        kd_pkg::patch_t patch;
        kd_pkg::leaf_t  leaf;
    } row_t;

    // outstanding result with its issue cycle
    typedef struct packed {
        kd_pkg::leaf_t leaf;
        logic [31:0]   cyc;
    } expect_t;

    logic               clk;
    logic               rst_n;
    logic               cfg_load_i;
    kd_pkg::node_cfg_t  cfg_data_i;
    logic               host_we_i;
    logic               host_re_i;
    kd_pkg::node_addr_t host_addr_i;
    kd_pkg::node_cfg_t  host_data_i;
    logic               host_rd_valid_o;
    kd_pkg::node_cfg_t  host_rd_data_o;
    logic               patch_valid_i;
    kd_pkg::patch_t     patch_i;
    logic               leaf_valid_o;
    kd_pkg::leaf_t      leaf_index_o;

    // stimulus table with node words then patch rows
    kd_pkg::node_cfg_t node_tbl [NODES];
    row_t              rows [N_ROWS];

    // what the tree should hold right now
    kd_pkg::node_cfg_t model [NODES];

    expect_t     exp_q [$];
    logic [31:0] cyc;
    logic [31:0] rng_state;

    kd_search_top #(
        .DEPTH (DEPTH)
    ) u_kd_search_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_load_i      (cfg_load_i),
        .cfg_data_i      (cfg_data_i),
        .host_we_i       (host_we_i),
        .host_re_i       (host_re_i),
        .host_addr_i     (host_addr_i),
        .host_data_i     (host_data_i),
        .host_rd_valid_o (host_rd_valid_o),
        .host_rd_data_o  (host_rd_data_o),
        .patch_valid_i   (patch_valid_i),
        .patch_i         (patch_i),
        .leaf_valid_o    (leaf_valid_o),
        .leaf_index_o    (leaf_index_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cycle count read on falling edges only
    initial cyc = '0;
    always @(posedge clk) cyc <= cyc + 32'd1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // root to leaf walk over the model
    // greater goes right and the first decision ends as msb
    function automatic kd_pkg::leaf_t walk(input kd_pkg::patch_t p);
        int                pos;
        kd_pkg::node_cfg_t n;
        pos = 0;
        for (int lvl = 0; lvl < DEPTH; lvl++) begin
            n   = model[(2**lvl) - 1 + pos];
            pos = 2 * pos + ((p[n.dim] > n.median) ? 1 : 0);
        end
        return kd_pkg::leaf_t'(pos);
    endfunction

    task automatic fill_table();
        // root splits on element 0 and each deeper level on the next one
        node_tbl[0]  = '{dim: 2'd0, median: 8'd128};
        node_tbl[1]  = '{dim: 2'd1, median: 8'd100};
        node_tbl[2]  = '{dim: 2'd1, median: 8'd150};
        node_tbl[3]  = '{dim: 2'd2, median: 8'd50};
        node_tbl[4]  = '{dim: 2'd2, median: 8'd60};
        node_tbl[5]  = '{dim: 2'd2, median: 8'd70};
        node_tbl[6]  = '{dim: 2'd2, median: 8'd80};
        node_tbl[7]  = '{dim: 2'd3, median: 8'd20};
        node_tbl[8]  = '{dim: 2'd3, median: 8'd40};
        node_tbl[9]  = '{dim: 2'd3, median: 8'd60};
        node_tbl[10] = '{dim: 2'd3, median: 8'd80};
        node_tbl[11] = '{dim: 2'd3, median: 8'd100};
        node_tbl[12] = '{dim: 2'd3, median: 8'd120};
        node_tbl[13] = '{dim: 2'd3, median: 8'd140};
        node_tbl[14] = '{dim: 2'd3, median: 8'd160};
        // patches as {e3 e2 e1 e0}
        // leaves worked out by hand
        rows[0] = '{patch: {8'd0, 8'd0, 8'd0, 8'd0}, leaf: 6'd0};
        rows[1] = '{patch: {8'd255, 8'd255, 8'd255, 8'd255}, leaf: 6'd15};
        // ties all stay left except the last level
        rows[2] = '{patch: {8'd21, 8'd50, 8'd100, 8'd128}, leaf: 6'd1};
        rows[3] = '{patch: {8'd120, 8'd71, 8'd150, 8'd129}, leaf: 6'd10};
        rows[4] = '{patch: {8'd61, 8'd60, 8'd101, 8'd10}, leaf: 6'd5};
        rows[5] = '{patch: {8'd200, 8'd80, 8'd151, 8'd200}, leaf: 6'd13};
        rows[6] = '{patch: {8'd40, 8'd51, 8'd50, 8'd50}, leaf: 6'd2};
        rows[7] = '{patch: {8'd101, 8'd5, 8'd10, 8'd130}, leaf: 6'd9};
        // nodes come out of reset cleared
        for (int a = 0; a < NODES; a++) begin
            model[a] = '0;
        end
    endtask

    // all tasks below start and end on a falling edge
    task automatic send_patch(input kd_pkg::patch_t p, input kd_pkg::leaf_t leaf);
        expect_t e;
        e.leaf = leaf;
        e.cyc  = cyc;
        patch_valid_i = 1'b1;
        patch_i       = p;
        exp_q.push_back(e);
        @(negedge clk);
        patch_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // quiet cycles where a stray pulse trips the monitor
        repeat (3) @(negedge clk);
    endtask

    task automatic load_tree();
        for (int a = 0; a < NODES; a++) begin
            cfg_load_i = 1'b1;
            cfg_data_i = node_tbl[a];
            model[a]   = node_tbl[a];
            @(negedge clk);
        end
        cfg_load_i = 1'b0;
    endtask

    task automatic read_check(input int addr);
        logic [31:0] want;
        if (addr < NODES) begin
            want = 32'(model[addr]);
        end else begin
            want = 32'd0;
        end
        host_re_i   = 1'b1;
        host_addr_i = kd_pkg::node_addr_t'(addr);
        @(negedge clk);
        host_re_i = 1'b0;
        check_eq(32'(host_rd_valid_o), 32'd1, "read strobe one cycle after host_re_i");
        check_eq(32'(host_rd_data_o), want, $sformatf("readback of node %0d", addr));
        @(negedge clk);
        check_eq(32'(host_rd_valid_o), 32'd0, "read strobe longer than one cycle");
    endtask

    task automatic run_random(input int n);
        kd_pkg::patch_t p;
        for (int i = 0; i < n; i++) begin
            rng_state = next_rand(rng_state);
            p = kd_pkg::patch_t'(rng_state);
            send_patch(p, walk(p));
        end
    endtask

    // result monitor expects in-order results exactly LAT cycles late
    always @(negedge clk) begin
        expect_t e;
        if (leaf_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("leaf_valid_o pulsed with no patch outstanding");
            end else begin
                e = exp_q.pop_front();
                check_eq(32'(leaf_index_o), 32'(e.leaf), "leaf index");
                check_eq(cyc - e.cyc, 32'(LAT), "cycles from patch to leaf");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout, run went past %0d clock cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rst_n         = 1'b0;
        cfg_load_i    = 1'b0;
        cfg_data_i    = '0;
        host_we_i     = 1'b0;
        host_re_i     = 1'b0;
        host_addr_i   = '0;
        host_data_i   = '0;
        patch_valid_i = 1'b0;
        patch_i       = '0;
        rng_state     = 32'd97;
        fill_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // stream load then read every node and one past the end
        load_tree();
        for (int a = 0; a <= NODES; a++) begin
            read_check(a);
        end

        // table rows back to back with the model cross-checked against the table
        for (int r = 0; r < N_ROWS; r++) begin
            check_eq(32'(walk(rows[r].patch)), 32'(rows[r].leaf), "reference walk vs table");
            send_patch(rows[r].patch, rows[r].leaf);
        end
        wait_drain();

        // same rows with idle gaps of 0 to 2 cycles
        for (int r = 0; r < N_ROWS; r++) begin
            send_patch(rows[r].patch, rows[r].leaf);
            repeat (r % 3) @(negedge clk);
        end
        wait_drain();

        // one random patch per cycle
        run_random(N_RAND);
        wait_drain();

        // host write to node 5 beats a stream word while the counter sits at the root
        host_we_i   = 1'b1;
        host_addr_i = kd_pkg::node_addr_t'(5);
        host_data_i = '{dim: 2'd0, median: 8'd0};
        cfg_load_i  = 1'b1;
        cfg_data_i  = '{dim: 2'd3, median: 8'd7};
        @(negedge clk);
        host_we_i  = 1'b0;
        // held counter puts this one on the root
        cfg_data_i = '{dim: 2'd1, median: 8'd90};
        @(negedge clk);
        cfg_load_i = 1'b0;
        model[5] = '{dim: 2'd0, median: 8'd0};
        model[0] = '{dim: 2'd1, median: 8'd90};
        read_check(0);
        read_check(1);
        read_check(5);
        run_random(16);
        // steered through node 5 where the new word sends it right
        send_patch({8'd0, 8'd0, 8'd120, 8'd1}, walk({8'd0, 8'd0, 8'd120, 8'd1}));
        wait_drain();

        // three patches in flight and a read then reset
        for (int r = 0; r < 3; r++) begin
            send_patch(rows[r].patch, rows[r].leaf);
        end
        rst_n     = 1'b0;
        host_re_i = 1'b1;
        exp_q.delete();
        for (int c = 0; c < 8 + LAT + 2; c++) begin
            @(negedge clk);
            host_re_i = 1'b0;
            if (c == 7) begin
                rst_n = 1'b1;
            end
            check_eq(32'(leaf_valid_o), 32'd0, "leaf_valid_o after reset");
            check_eq(32'(host_rd_valid_o), 32'd0, "host_rd_valid_o after reset");
        end
        for (int a = 0; a < NODES; a++) begin
            model[a] = '0;
        end
        read_check(3);

        // reload must start again at the root
        load_tree();
        read_check(0);
        read_check(NODES - 1);
        for (int r = 0; r < N_ROWS; r++) begin
            send_patch(rows[r].patch, rows[r].leaf);
        end
        wait_drain();

        $display("No errors");
        $finish;
    end

endmodule
